// File: ntm_cfg.svh
`ifndef NTM_CFG_SVH
`define NTM_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Data words and products, wrap-around arithmetic
`define NTM_DATA_SIZE 32

// Sizes and loop indices
`define NTM_INDEX_SIZE 8

////////////////////////////////////////////////////////////////////////////
// Flow control
////////////////////////////////////////////////////////////////////////////

// Input FIFO depth, equal to source credits after reset
`define NTM_IN_DEPTH 4

// Output credits held after reset
`define NTM_OUT_CREDITS 2

`endif

// File: ntm_pkg.sv
`include "ntm_cfg.svh"

package ntm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`NTM_DATA_SIZE-1:0]  ntm_data_t;
  typedef logic [`NTM_INDEX_SIZE-1:0] ntm_index_t;

  // Register map
  typedef enum logic [1:0] {
    REG_SIZE_I  = 2'd0,  // Row count
    REG_SIZE_J  = 2'd1,  // Column count
    REG_LENGTH  = 2'd2,  // Words per product
    REG_CONTROL = 2'd3   // Any write starts a job
  } ntm_reg_e;

  // Sequencer FSM
  typedef enum logic [1:0] {
    IDLE,
    FEED,
    WAIT_PRODUCT,
    SEND
  } ntm_seq_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  // One configuration write
  typedef struct packed {
    logic       valid;
    ntm_reg_e   addr;
    ntm_index_t data;
  } ntm_cfg_write_t;

  // Job dimensions
  typedef struct packed {
    ntm_index_t size_i;
    ntm_index_t size_j;
    ntm_index_t length;
  } ntm_sizes_t;

  // One reduced result
  typedef struct packed {
    ntm_index_t row;
    ntm_index_t col;
    ntm_data_t  product;
    logic       last;
  } ntm_result_t;

endpackage

// File: ntm_mult_regs.sv
`timescale 1ns/1ps

module ntm_mult_regs
  import ntm_pkg::*;
(
  input  logic           CLK,
  input  logic           RST,
  input  ntm_cfg_write_t cfg,
  input  logic           done,
  output ntm_sizes_t     sizes,
  output logic           start,
  output logic           busy
);

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////

  logic wr_en;

  // Writes only land between jobs
  // Start cycle counts as busy so no size slips in late
  assign wr_en = cfg.valid && !busy && !start;

  ////////////////////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      start <= 1'b0;
      busy  <= 1'b0;
    end else begin
      // One-cycle pulse after a control write
      start <= wr_en && (cfg.addr == REG_CONTROL);

      // Busy from cycle after start until cycle after done
      if (start) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Size registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      case (cfg.addr)
        REG_SIZE_I:  sizes.size_i <= cfg.data;
        REG_SIZE_J:  sizes.size_j <= cfg.data;
        REG_LENGTH:  sizes.length <= cfg.data;
        // Control write carries no stored data
        REG_CONTROL: sizes <= sizes;
        default:     sizes <= sizes;
      endcase
    end
  end

endmodule

// File: ntm_input_buffer.sv
`timescale 1ns/1ps
`include "ntm_cfg.svh"

module ntm_input_buffer
  import ntm_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      in_valid,
  input  ntm_data_t in_data,
  input  logic      pop,
  output ntm_data_t head,
  output logic      not_empty,
  output logic      in_credit
);

  localparam int DEPTH = `NTM_IN_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  ntm_data_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  // Circular increment for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];
  assign do_pop    = pop && not_empty;

  // Credit goes back the same cycle the word leaves
  assign in_credit = do_pop;

  // Payload only, source credits keep it from overflowing
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Occupancy, push and pop together leave it unchanged
      case ({in_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: ntm_vector_multiplication.sv
`timescale 1ns/1ps

module ntm_vector_multiplication
  import ntm_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      acc_first,
  input  logic      acc_last,
  input  logic      acc_valid,
  input  ntm_data_t acc_data,
  output ntm_data_t product,
  output logic      product_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // Running product
  ////////////////////////////////////////////////////////////////////////////

  ntm_data_t next_product;

  // First word seeds the run, later words multiply in
  // Low NTM_DATA_SIZE bits kept, upper bits dropped
  always_comb begin
    if (acc_first) begin
      next_product = acc_data;
    end else begin
      next_product = product * acc_data;
    end
  end

  // Accumulator register, seeded by every first word
  always_ff @(posedge CLK) begin
    if (acc_valid) begin
      product <= next_product;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Completion flag
  ////////////////////////////////////////////////////////////////////////////

  // One cycle after the last word of the run
  // Same edge that writes the final factor
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      product_valid <= 1'b0;
    end else begin
      product_valid <= acc_valid && acc_last;
    end
  end

endmodule

// File: ntm_matrix_multiplication.sv
`timescale 1ns/1ps
`include "ntm_cfg.svh"

module ntm_matrix_multiplication
  import ntm_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  ntm_sizes_t  sizes,
  input  logic        start,
  output logic        done,
  input  ntm_data_t   head,
  input  logic        not_empty,
  output logic        pop,
  input  ntm_data_t   product,
  input  logic        product_valid,
  output logic        acc_first,
  output logic        acc_last,
  output logic        acc_valid,
  output ntm_data_t   acc_data,
  output ntm_result_t result,
  output logic        result_valid,
  input  logic        out_credit
);

  localparam int CREDIT_W = $clog2(`NTM_OUT_CREDITS + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Indices and flags
  ////////////////////////////////////////////////////////////////////////////

  ntm_seq_state_e      state;
  ntm_index_t          row;
  ntm_index_t          col;
  ntm_index_t          scalar;
  logic [CREDIT_W-1:0] credits;
  logic                row_last;
  logic                col_last;
  logic                scalar_last;
  logic                send;

  assign row_last    = (row == sizes.size_i - ntm_index_t'(1));
  assign col_last    = (col == sizes.size_j - ntm_index_t'(1));
  assign scalar_last = (scalar == sizes.length - ntm_index_t'(1));

  // Feed accumulator straight from FIFO head
  assign pop       = (state == FEED) && not_empty;
  assign acc_valid = pop;
  assign acc_data  = head;
  assign acc_first = (scalar == '0);
  assign acc_last  = scalar_last;

  // Send needs a credit in hand
  assign send         = (state == SEND) && (credits != '0);
  assign result_valid = send;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= IDLE;
      row    <= '0;
      col    <= '0;
      scalar <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            row    <= '0;
            col    <= '0;
            scalar <= '0;
            state  <= FEED;
          end
        end
        FEED: begin
          // One word per cycle while the FIFO has data
          if (pop) begin
            if (scalar_last) begin
              scalar <= '0;
              state  <= WAIT_PRODUCT;
            end else begin
              scalar <= scalar + 1'b1;
            end
          end
        end
        WAIT_PRODUCT: begin
          if (product_valid) begin
            state <= SEND;
          end
        end
        SEND: begin
          // Holds here until a credit shows up
          if (send) begin
            if (row_last && col_last) begin
              done  <= 1'b1;
              state <= IDLE;
            end else begin
              if (col_last) begin
                col <= '0;
                row <= row + 1'b1;
              end else begin
                col <= col + 1'b1;
              end
              state <= FEED;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Result payload captured with its indices
  always_ff @(posedge CLK) begin
    if ((state == WAIT_PRODUCT) && product_valid) begin
      result.row     <= row;
      result.col     <= col;
      result.product <= product;
      result.last    <= row_last && col_last;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output credits
  ////////////////////////////////////////////////////////////////////////////

  // Return and send in one cycle cancel out
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits <= CREDIT_W'(`NTM_OUT_CREDITS);
    end else begin
      case ({out_credit, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// File: ntm_top.sv
`timescale 1ns/1ps

module ntm_top
  import ntm_pkg::*;
(
  input  logic           CLK,
  input  logic           RST,
  input  ntm_cfg_write_t cfg,
  output logic           busy,
  input  logic           in_valid,
  input  ntm_data_t      in_data,
  output logic           in_credit,
  output ntm_result_t    result,
  output logic           result_valid,
  input  logic           out_credit
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////////////////////

  // Register block to sequencer
  ntm_sizes_t sizes;
  logic       start;
  logic       done;

  // FIFO to sequencer
  ntm_data_t  head;
  logic       not_empty;
  logic       pop;

  // Sequencer to accumulator and back
  ntm_data_t  product;
  logic       product_valid;
  logic       acc_first;
  logic       acc_last;
  logic       acc_valid;
  ntm_data_t  acc_data;

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  ntm_mult_regs u_regs (
    .CLK   (CLK),
    .RST   (RST),
    .cfg   (cfg),
    .done  (done),
    .sizes (sizes),
    .start (start),
    .busy  (busy)
  );

  ntm_input_buffer u_input_buffer (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .in_credit (in_credit)
  );

  ntm_matrix_multiplication u_matrix_multiplication (
    .CLK           (CLK),
    .RST           (RST),
    .sizes         (sizes),
    .start         (start),
    .done          (done),
    .head          (head),
    .not_empty     (not_empty),
    .pop           (pop),
    .product       (product),
    .product_valid (product_valid),
    .acc_first     (acc_first),
    .acc_last      (acc_last),
    .acc_valid     (acc_valid),
    .acc_data      (acc_data),
    .result        (result),
    .result_valid  (result_valid),
    .out_credit    (out_credit)
  );

  ntm_vector_multiplication u_vector_multiplication (
    .CLK           (CLK),
    .RST           (RST),
    .acc_first     (acc_first),
    .acc_last      (acc_last),
    .acc_valid     (acc_valid),
    .acc_data      (acc_data),
    .product       (product),
    .product_valid (product_valid)
  );

endmodule

// File: ntm_assertions.sv
`timescale 1ns/1ps
`include "ntm_cfg.svh"

module ntm_assertions
  import ntm_pkg::*;
(
  input logic           CLK,
  input logic           RST,
  input ntm_seq_state_e state,
  input logic           start,
  input logic           send_valid,
  input logic           result_last,
  input logic           done,
  input logic           out_credit,
  input logic           buf_write,
  input logic           buf_full
);

  // Credits held by the sequencer, rebuilt from returns and sends
  int   held;

  // Job window from start pulse to done pulse
  logic in_job;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      held   <= `NTM_OUT_CREDITS;
      in_job <= 1'b0;
    end else begin
      held <= held + int'(out_credit) - int'(send_valid);
      if (start) begin
        in_job <= 1'b1;
      end else if (done) begin
        in_job <= 1'b0;
      end
    end
  end

  // Results only go out against a held credit
  send_needs_credit: assert property (@(posedge CLK) disable iff (RST)
    send_valid |-> (held > 0))
    else $error("result sent with zero output credits");

  // Source credits keep the FIFO from overflowing
  no_write_when_full: assert property (@(posedge CLK) disable iff (RST)
    buf_write |-> !buf_full)
    else $error("input FIFO written while full");

  // End of job is the last result then done
  done_after_last: assert property (@(posedge CLK) disable iff (RST)
    (send_valid && result_last) |=> done)
    else $error("done missing after last result");

  // Outside a job the FSM rests in IDLE with no result
  quiet_in_idle: assert property (@(posedge CLK) disable iff (RST)
    !in_job |-> ((state == IDLE) && !send_valid))
    else $error("result_valid high or FSM busy outside a job");

endmodule

// Sequencer side, FIFO inputs tied off
bind ntm_matrix_multiplication ntm_assertions u_seq_assertions (
  .CLK         (CLK),
  .RST         (RST),
  .state       (state),
  .start       (start),
  .send_valid  (result_valid),
  .result_last (result.last),
  .done        (done),
  .out_credit  (out_credit),
  .buf_write   (1'b0),
  .buf_full    (1'b0)
);

// FIFO side, sequencer inputs tied off
bind ntm_input_buffer ntm_assertions u_buf_assertions (
  .CLK         (CLK),
  .RST         (RST),
  .state       (ntm_pkg::IDLE),
  .start       (1'b0),
  .send_valid  (1'b0),
  .result_last (1'b0),
  .done        (1'b0),
  .out_credit  (1'b0),
  .buf_write   (in_valid),
  .buf_full    (count == CNT_W'(DEPTH))
);

// File: ntm_tb.sv
`timescale 1ns/1ps
`include "ntm_cfg.svh"

module ntm_tb
  import ntm_pkg::*;
();

  typedef ntm_result_t result_q_t[$];

  ////////////////////////////////////////////////////////////////////////////
  // DUT connections and bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  logic           CLK;
  logic           RST;
  ntm_cfg_write_t cfg;
  logic           busy;
  logic           in_valid;
  ntm_data_t      in_data;
  logic           in_credit;
  ntm_result_t    result;
  logic           result_valid;
  logic           out_credit;

  // Words still to send, current job's words, expected results
  ntm_data_t src_q[$];
  ntm_data_t words[$];
  result_q_t exp_q;
  int        seed;
  string     test_name;

  // Source credits spent and returned, sink results seen and credited
  int spent;
  int returned;
  int seen;
  int given;
  int sink_gap;
  int sink_wait;

  int errors;
  int test_errors;
  int tests_passed;
  int tests_failed;
  int cycles;
  int cycle_limit;

  ntm_top UUT (
    .CLK          (CLK),
    .RST          (RST),
    .cfg          (cfg),
    .busy         (busy),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .in_credit    (in_credit),
    .result       (result),
    .result_valid (result_valid),
    .out_credit   (out_credit)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Row-major pairs, length words each, product wraps in data width
  function automatic result_q_t ref_products(input ntm_sizes_t sz, input ntm_data_t w[$]);
    result_q_t   q;
    ntm_result_t r;
    int          idx;
    idx = 0;
    for (int i = 0; i < int'(sz.size_i); i++) begin
      for (int j = 0; j < int'(sz.size_j); j++) begin
        r.row     = ntm_index_t'(i);
        r.col     = ntm_index_t'(j);
        r.product = ntm_data_t'(1);
        for (int k = 0; k < int'(sz.length); k++) begin
          r.product = r.product * w[idx];
          idx++;
        end
        r.last = (i == int'(sz.size_i) - 1) && (j == int'(sz.size_j) - 1);
        q.push_back(r);
      end
    end
    return q;
  endfunction

  task automatic check_result(input ntm_result_t exp, input ntm_result_t act);
    string exp_s;
    string act_s;
    if (exp !== act) begin
      errors++;
      test_errors++;
      exp_s = $sformatf("row=%0d col=%0d product=%h last=%b",
                        exp.row, exp.col, exp.product, exp.last);
      act_s = $sformatf("row=%0d col=%0d product=%h last=%b",
                        act.row, act.col, act.product, act.last);
      $display("Error: %s result expected %s actual %s", test_name, exp_s, act_s);
    end
  endtask

  task automatic check_busy(input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("Error: %s busy expected %b actual %b", test_name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // One config write, one cycle wide
  task automatic write_cfg(input ntm_reg_e addr, input int data);
    @(negedge CLK);
    cfg.valid = 1'b1;
    cfg.addr  = addr;
    cfg.data  = ntm_index_t'(data);
    @(negedge CLK);
    cfg.valid = 1'b0;
  endtask

  task automatic configure(input int si, input int sj, input int len);
    write_cfg(REG_SIZE_I, si);
    write_cfg(REG_SIZE_J, sj);
    write_cfg(REG_LENGTH, len);
  endtask

  // Builds the words, queues them at the source, sets expected results
  task automatic load_job(input int si, input int sj, input int len, input bit fixed);
    ntm_sizes_t sz;
    sz.size_i = ntm_index_t'(si);
    sz.size_j = ntm_index_t'(sj);
    sz.length = ntm_index_t'(len);
    words.delete();
    for (int k = 0; k < si * sj * len; k++) begin
      words.push_back(fixed ? ntm_data_t'(k + 1) : ntm_data_t'($random(seed)));
    end
    exp_q = ref_products(sz, words);
    foreach (words[k]) src_q.push_back(words[k]);
  endtask

  // All results in, then done, then busy falls one cycle later
  // Sink credits handed back before the next job
  task automatic wait_results();
    while (exp_q.size() != 0) @(negedge CLK);
    check_busy(1'b1, busy);
    @(negedge CLK);
    check_busy(1'b0, busy);
    while (seen != given) @(posedge CLK);
  endtask

  task automatic run_job(input int si, input int sj, input int len, input bit fixed);
    configure(si, sj, len);
    load_job(si, sj, len, fixed);
    write_cfg(REG_CONTROL, 0);
    wait_results();
  endtask

  task automatic begin_test(input string name, input int gap);
    test_name   = name;
    test_errors = 0;
    sink_gap    = gap;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", test_name, test_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Source, sink, compare and timeout processes
  ////////////////////////////////////////////////////////////////////////////

  // Send only while a credit is held
  always @(negedge CLK) begin
    if (!RST && src_q.size() != 0 && (spent - returned) < `NTM_IN_DEPTH) begin
      in_valid = 1'b1;
      in_data  = src_q.pop_front();
      spent++;
    end else begin
      in_valid = 1'b0;
    end
  end

  // Credits only come back for words already in the FIFO
  // Word presented this edge is not yet poppable
  always @(posedge CLK) begin
    if (in_credit && (spent - int'(in_valid) - returned) <= 0) begin
      errors++;
      test_errors++;
      $display("Input credit returned with no word buffered in %s", test_name);
    end
    if (in_credit) returned++;
  end

  // Sink returns one credit per result after sink_gap idle cycles
  always @(negedge CLK) begin
    out_credit = 1'b0;
    if (!RST && seen > given) begin
      if (sink_wait >= sink_gap) begin
        out_credit = 1'b1;
        given++;
        sink_wait = 0;
      end else begin
        sink_wait++;
      end
    end
  end

  always @(posedge CLK) begin
    if (!RST && result_valid) begin
      seen++;
      if (exp_q.size() == 0) begin
        errors++;
        test_errors++;
        $display("Result arrived with nothing left to expect in %s", test_name);
      end else begin
        check_result(exp_q.pop_front(), result);
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: results stopped arriving after %0d cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int rs_i[3];
    int rs_j[3];
    int rs_l[3];
    int total;
    CLK          = 1'b0;
    RST          = 1'b1;
    cfg          = '0;
    in_valid     = 1'b0;
    in_data      = '0;
    out_credit   = 1'b0;
    seed         = 74;
    spent        = 0;
    returned     = 0;
    seen         = 0;
    given        = 0;
    sink_gap     = 0;
    sink_wait    = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles       = 0;
    cycle_limit  = 0;
    test_name    = "reset";

    // Random sizes drawn up front so the word total is known
    total = 24 + 6 + 12 + 8 + 6;
    for (int n = 0; n < 3; n++) begin
      rs_i[n] = 1 + int'($unsigned($random(seed)) % 5);
      rs_j[n] = 1 + int'($unsigned($random(seed)) % 5);
      rs_l[n] = 1 + int'($unsigned($random(seed)) % 5);
      total   = total + rs_i[n] * rs_j[n] * rs_l[n];
    end
    cycle_limit = 20 * total;

    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    begin_test("fixed_2x3x4", 0);
    run_job(2, 3, 4, 1'b1);
    end_test();

    begin_test("random_sizes", 0);
    for (int n = 0; n < 3; n++) run_job(rs_i[n], rs_j[n], rs_l[n], 1'b0);
    end_test();

    // First word is also the last
    begin_test("length_one", 0);
    run_job(3, 2, 1, 1'b0);
    end_test();

    begin_test("output_backpressure", 15);
    run_job(2, 3, 2, 1'b0);
    end_test();

    // Writes during the job must be dropped
    // Start pulse one cycle after the write, busy one cycle after start
    begin_test("busy_and_ignored_writes", 0);
    configure(2, 2, 2);
    load_job(2, 2, 2, 1'b0);
    write_cfg(REG_CONTROL, 0);
    check_busy(1'b0, busy);
    @(negedge CLK);
    check_busy(1'b1, busy);
    write_cfg(REG_SIZE_I, 3);
    write_cfg(REG_LENGTH, 5);
    wait_results();
    run_job(1, 3, 2, 1'b0);
    end_test();

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
ntm_pkg.sv
ntm_mult_regs.sv
ntm_input_buffer.sv
ntm_vector_multiplication.sv
ntm_matrix_multiplication.sv
ntm_top.sv
ntm_assertions.sv
ntm_tb.sv

// File: Makefile
# Verilator build and run for the tensor reduction unit

TOP = ntm_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

# Pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^All tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
